// File: hw/tex_consts.svh
`ifndef TEX_CONSTS_SVH
`define TEX_CONSTS_SVH

// texture side as a power of two, 3 to 5 supported
`define TEX_LOG_DIM 4
`define TEX_DIM (1 << `TEX_LOG_DIM)
`define TEX_NUM_WORDS (`TEX_DIM * `TEX_DIM)

// texel address is row then column
`define TEX_ADDR_BITS (2 * `TEX_LOG_DIM)

// fixed-point coordinate, integer part spans the texture side
`define TEX_FRAC_BITS 4
`define TEX_COORD_BITS (`TEX_LOG_DIM + `TEX_FRAC_BITS)

// texel format codes, code 3 unused
`define TEX_FMT_BITS 2
`define TEX_FMT_R5G6B5 0
`define TEX_FMT_R8G8B8 1
`define TEX_FMT_R8G8B8A8 2

// bilinear footprint and lane layout
`define TEX_NUM_TEXELS 4
`define TEX_NUM_CHANNELS 4
`define TEX_COLOR_BITS 8
`define TEX_LANE_BITS 16

`endif

// File: hw/tex_pkg.sv
`include "tex_consts.svh"

package tex_pkg;

    // coordinate, integer bits above fraction bits
    typedef logic [`TEX_COORD_BITS-1:0] tex_coord_t;
    // integer part of a coordinate, wraps on overflow
    typedef logic [`TEX_LOG_DIM-1:0] tex_int_t;
    typedef logic [`TEX_FRAC_BITS-1:0] tex_frac_t;
    // blend weight, one bit wider to hold a full 1.0
    typedef logic [`TEX_FRAC_BITS:0] tex_weight_t;
    typedef logic [`TEX_ADDR_BITS-1:0] tex_addr_t;

    typedef logic [31:0] texel_raw_t;
    // one 8-bit channel value
    typedef logic [`TEX_COLOR_BITS-1:0] tex_chan_t;
    // channel in low byte, high byte kept zero
    typedef logic [`TEX_LANE_BITS-1:0] tex_lane_t;
    // lanes r, g, b, a from high to low
    typedef logic [`TEX_NUM_CHANNELS*`TEX_LANE_BITS-1:0] texel_exp_t;

    // bit 3 is r, bit 0 is a
    typedef logic [`TEX_NUM_CHANNELS-1:0] color_en_t;
    // r in the top byte
    typedef logic [`TEX_NUM_CHANNELS*`TEX_COLOR_BITS-1:0] rgba_t;

    typedef enum logic [`TEX_FMT_BITS-1:0] {
        fmt_r5g6b5   = `TEX_FMT_BITS'(`TEX_FMT_R5G6B5),
        fmt_r8g8b8   = `TEX_FMT_BITS'(`TEX_FMT_R8G8B8),
        fmt_r8g8b8a8 = `TEX_FMT_BITS'(`TEX_FMT_R8G8B8A8)
    } tex_format_e;

endpackage

// File: hw/tex_stage_if.sv
`include "tex_consts.svh"

interface tex_stage_if
    import tex_pkg::*;
();

    // one-cycle strobe per request
    logic valid;
    tex_format_e fmt;

    // blend fractions of the footprint
    tex_frac_t frac_u;
    tex_frac_t frac_v;

    // footprint order (x,y) (x+1,y) (x,y+1) (x+1,y+1)
    tex_addr_t [`TEX_NUM_TEXELS-1:0] addr;

    // raw words from texture memory
    texel_raw_t [`TEX_NUM_TEXELS-1:0] raw;

    // expanded lanes and channel mask
    texel_exp_t [`TEX_NUM_TEXELS-1:0] texel;
    color_en_t color_en;

    // producing stage
    modport src (
        output valid,
        output fmt,
        output frac_u,
        output frac_v,
        output addr,
        output raw,
        output texel,
        output color_en
    );

    // consuming stage
    modport dst (
        input valid,
        input fmt,
        input frac_u,
        input frac_v,
        input addr,
        input raw,
        input texel,
        input color_en
    );

endinterface

// File: hw/tex_addr.sv
`include "tex_consts.svh"

module tex_addr
    import tex_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  tex_coord_t  req_u,
    input  tex_coord_t  req_v,
    input  tex_format_e req_fmt,
    tex_stage_if.src    out
);

    // integer parts and their right and lower neighbours
    tex_int_t x0;
    tex_int_t x1;
    tex_int_t y0;
    tex_int_t y1;
    tex_frac_t fu;
    tex_frac_t fv;

    // split coordinate at the binary point
    assign x0 = req_u[`TEX_COORD_BITS-1:`TEX_FRAC_BITS];
    assign y0 = req_v[`TEX_COORD_BITS-1:`TEX_FRAC_BITS];
    assign fu = req_u[`TEX_FRAC_BITS-1:0];
    assign fv = req_v[`TEX_FRAC_BITS-1:0];

    // width of tex_int_t gives wrap modulo side
    assign x1 = x0 + 1'b1;
    assign y1 = y0 + 1'b1;

    // valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= req_valid;
        end
    end

    // payload, address is row then column
    always_ff @(posedge clk) begin
        out.fmt     <= req_fmt;
        out.frac_u  <= fu;
        out.frac_v  <= fv;
        out.addr[0] <= {y0, x0};
        out.addr[1] <= {y0, x1};
        out.addr[2] <= {y1, x0};
        out.addr[3] <= {y1, x1};
    end

    // nothing upstream for later fields
    assign out.raw      = '0;
    assign out.texel    = '0;
    assign out.color_en = '0;

    // format code 3 has no expansion rule downstream
    a_fmt_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> req_fmt inside {fmt_r5g6b5, fmt_r8g8b8, fmt_r8g8b8a8}
    );

endmodule

// File: hw/tex_mem.sv
`include "tex_consts.svh"

module tex_mem
    import tex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  tex_addr_t  wr_addr,
    input  texel_raw_t wr_data,
    tex_stage_if.dst   in,
    tex_stage_if.src   out
);

    // texture storage, one word per texel
    texel_raw_t mem [0:`TEX_NUM_WORDS-1];

    // load port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // four reads every cycle
    // same-address write lands after the read, old word returned
    always_ff @(posedge clk) begin
        for (int i = 0; i < `TEX_NUM_TEXELS; i++) begin
            out.raw[i] <= mem[in.addr[i]];
        end
    end

    // valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    // forwarded payload kept in step with the read data
    always_ff @(posedge clk) begin
        out.fmt      <= in.fmt;
        out.frac_u   <= in.frac_u;
        out.frac_v   <= in.frac_v;
        out.addr     <= in.addr;
        out.texel    <= in.texel;
        out.color_en <= in.color_en;
    end

    // an unknown address would corrupt an arbitrary texel
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr)
    );

endmodule

// File: hw/tex_format.sv
`include "tex_consts.svh"

module tex_format
    import tex_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    tex_stage_if.dst in,
    tex_stage_if.src out
);

    texel_exp_t [`TEX_NUM_TEXELS-1:0] texel_c;
    color_en_t color_en_c;

    // channel into low byte, high byte zero
    function automatic tex_lane_t lane(input tex_chan_t c);
        return {{(`TEX_LANE_BITS - `TEX_COLOR_BITS){1'b0}}, c};
    endfunction

    // zero-extend each channel of one raw word
    function automatic texel_exp_t expand(input texel_raw_t raw, input tex_format_e fmt);
        tex_chan_t r;
        tex_chan_t g;
        tex_chan_t b;
        tex_chan_t a;
        case (fmt)
            fmt_r5g6b5: begin
                r = tex_chan_t'(raw[15:11]);
                g = tex_chan_t'(raw[10:5]);
                b = tex_chan_t'(raw[4:0]);
                a = '0;
            end
            fmt_r8g8b8: begin
                r = raw[23:16];
                g = raw[15:8];
                b = raw[7:0];
                a = '0;
            end
            // r8g8b8a8, illegal code caught upstream
            default: begin
                r = raw[31:24];
                g = raw[23:16];
                b = raw[15:8];
                a = raw[7:0];
            end
        endcase
        return {lane(r), lane(g), lane(b), lane(a)};
    endfunction

    always_comb begin
        for (int i = 0; i < `TEX_NUM_TEXELS; i++) begin
            texel_c[i] = expand(in.raw[i], in.fmt);
        end
    end

    // alpha only present in the 32-bit format
    assign color_en_c = (in.fmt == fmt_r8g8b8a8) ? 4'b1111 : 4'b1110;

    // valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    // expanded texels plus forwarded payload
    always_ff @(posedge clk) begin
        out.texel    <= texel_c;
        out.color_en <= color_en_c;
        out.fmt      <= in.fmt;
        out.frac_u   <= in.frac_u;
        out.frac_v   <= in.frac_v;
        out.addr     <= in.addr;
        out.raw      <= in.raw;
    end

    // filter relies on empty high bytes for product headroom
    for (genvar i = 0; i < `TEX_NUM_TEXELS; i++) begin : g_texel
        for (genvar c = 0; c < `TEX_NUM_CHANNELS; c++) begin : g_lane
            a_lane_hi_zero: assert property (
                @(posedge clk) disable iff (!rst_n)
                out.valid |->
                    out.texel[i][c*`TEX_LANE_BITS + `TEX_COLOR_BITS +:
                                 (`TEX_LANE_BITS - `TEX_COLOR_BITS)] == '0
            );
        end
    end

endmodule

// File: hw/tex_filter.sv
`include "tex_consts.svh"

module tex_filter
    import tex_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    tex_stage_if.dst in,
    output logic     rsp_valid,
    output rgba_t    rsp_color
);

    // weights for left/right and top/bottom
    tex_weight_t wu0;
    tex_weight_t wu1;
    tex_weight_t wv0;
    tex_weight_t wv1;
    rgba_t color_c;

    // one minus fraction, fraction
    assign wu1 = {1'b0, in.frac_u};
    assign wv1 = {1'b0, in.frac_v};
    assign wu0 = {1'b1, {`TEX_FRAC_BITS{1'b0}}} - wu1;
    assign wv0 = {1'b1, {`TEX_FRAC_BITS{1'b0}}} - wv1;

    // two-tap lerp, shift drops the fraction bits
    function automatic tex_chan_t lerp(
        input tex_chan_t   a,
        input tex_chan_t   b,
        input tex_weight_t w0,
        input tex_weight_t w1
    );
        tex_lane_t acc;
        acc = tex_lane_t'(a) * tex_lane_t'(w0) + tex_lane_t'(b) * tex_lane_t'(w1);
        return acc[`TEX_FRAC_BITS +: `TEX_COLOR_BITS];
    endfunction

    // per channel, lane c of texel k is channel c
    always_comb begin
        for (int c = 0; c < `TEX_NUM_CHANNELS; c++) begin
            if (in.color_en[c]) begin
                // horizontal first, then vertical
                color_c[c*`TEX_COLOR_BITS +: `TEX_COLOR_BITS] = lerp(
                    lerp(in.texel[0][c*`TEX_LANE_BITS +: `TEX_COLOR_BITS],
                         in.texel[1][c*`TEX_LANE_BITS +: `TEX_COLOR_BITS], wu0, wu1),
                    lerp(in.texel[2][c*`TEX_LANE_BITS +: `TEX_COLOR_BITS],
                         in.texel[3][c*`TEX_LANE_BITS +: `TEX_COLOR_BITS], wu0, wu1),
                    wv0, wv1);
            end else begin
                // missing channel reads as full
                color_c[c*`TEX_COLOR_BITS +: `TEX_COLOR_BITS] = 8'hff;
            end
        end
    end

    // response strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= in.valid;
        end
    end

    // response colour
    always_ff @(posedge clk) begin
        rsp_color <= color_c;
    end

    // back-to-back responses need back-to-back beats from format stage
    a_rsp_follows_in: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && $past(rsp_valid)) |-> $past(in.valid)
    );

endmodule

// File: hw/tex_unit.sv
`include "tex_consts.svh"

module tex_unit
    import tex_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // sample request, one per cycle at most
    input  logic        req_valid,
    input  tex_coord_t  req_u,
    input  tex_coord_t  req_v,
    input  tex_format_e req_fmt,

    // texture load port
    input  logic        wr_en,
    input  tex_addr_t   wr_addr,
    input  texel_raw_t  wr_data,

    // filtered colour, 4 cycles after request
    output logic        rsp_valid,
    output rgba_t       rsp_color
);

    // stage links
    tex_stage_if a2m ();
    tex_stage_if m2f ();
    tex_stage_if f2b ();

    // footprint addresses
    tex_addr u_addr (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_u     (req_u),
        .req_v     (req_v),
        .req_fmt   (req_fmt),
        .out       (a2m.src)
    );

    // texel fetch
    tex_mem u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .in      (a2m.dst),
        .out     (m2f.src)
    );

    // lane expansion
    tex_format u_format (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (m2f.dst),
        .out   (f2b.src)
    );

    // bilinear blend
    tex_filter u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (f2b.dst),
        .rsp_valid (rsp_valid),
        .rsp_color (rsp_color)
    );

endmodule

// File: bench/tb_tex_unit.sv
`include "tex_consts.svh"

module tb_tex_unit
    import tex_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // request counts per test
    localparam int NUM_POINT = 24;
    localparam int NUM_RAND = 60;
    localparam int NUM_B2B = 32;
    localparam int NUM_REWR = 4;
    localparam int NUM_REQS = NUM_POINT + NUM_RAND + NUM_B2B + 2 * NUM_REWR;
    localparam int NUM_WRITES = `TEX_NUM_WORDS + NUM_REWR;
    // a drained request costs about 6 cycles, a write one cycle
    localparam int MAX_CYCLES = 8 * NUM_REQS + 2 * NUM_WRITES + 200;

    // expected response with the request that caused it
    typedef struct {
        int          due;
        tex_coord_t  u;
        tex_coord_t  v;
        tex_format_e fmt;
        rgba_t       color;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    tex_coord_t  req_u;
    tex_coord_t  req_v;
    tex_format_e req_fmt;
    logic        wr_en;
    tex_addr_t   wr_addr;
    texel_raw_t  wr_data;
    logic        rsp_valid;
    rgba_t       rsp_color;

    // copy of the texture contents
    texel_raw_t shadow [0:`TEX_NUM_WORDS-1];
    exp_t exp_q [$];
    int cycle = 0;
    int seed = 32'hf4497da1;
    int n_checks = 0;
    int n_errors = 0;

    tex_unit DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_u     (req_u),
        .req_v     (req_v),
        .req_fmt   (req_fmt),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rsp_valid (rsp_valid),
        .rsp_color (rsp_color)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // counts rising edges since time zero
    always @(posedge clk) cycle <= cycle + 1;

    function automatic int rand_below(input int n);
        return int'({1'b0, $random(seed)} % n);
    endfunction

    function automatic tex_format_e fmt_pick(input int k);
        case (k % 3)
            0: return fmt_r5g6b5;
            1: return fmt_r8g8b8;
            default: return fmt_r8g8b8a8;
        endcase
    endfunction

    // expected colour from the shadow texture
    function automatic rgba_t ref_sample(
        input tex_coord_t  u,
        input tex_coord_t  v,
        input tex_format_e fmt
    );
        int scale;
        int x [2];
        int y [2];
        int fu;
        int fv;
        int top;
        int bot;
        int val;
        int ch [4][4];
        texel_raw_t t;
        rgba_t res;
        scale = 1 << `TEX_FRAC_BITS;
        x[0] = int'(u) / scale;
        y[0] = int'(v) / scale;
        fu = int'(u) % scale;
        fv = int'(v) % scale;
        // neighbours wrap around the texture edge
        x[1] = (x[0] + 1) % `TEX_DIM;
        y[1] = (y[0] + 1) % `TEX_DIM;
        for (int k = 0; k < 4; k++) begin
            t = shadow[y[k / 2] * `TEX_DIM + x[k % 2]];
            // channel order r, g, b, a
            case (fmt)
                fmt_r5g6b5: begin
                    ch[k][0] = int'(t[15:11]);
                    ch[k][1] = int'(t[10:5]);
                    ch[k][2] = int'(t[4:0]);
                    ch[k][3] = 0;
                end
                fmt_r8g8b8: begin
                    ch[k][0] = int'(t[23:16]);
                    ch[k][1] = int'(t[15:8]);
                    ch[k][2] = int'(t[7:0]);
                    ch[k][3] = 0;
                end
                default: begin
                    ch[k][0] = int'(t[31:24]);
                    ch[k][1] = int'(t[23:16]);
                    ch[k][2] = int'(t[15:8]);
                    ch[k][3] = int'(t[7:0]);
                end
            endcase
        end
        for (int c = 0; c < 4; c++) begin
            if (c == 3 && fmt != fmt_r8g8b8a8) begin
                // no alpha in the source, reads as opaque
                res[7:0] = 8'hff;
            end else begin
                top = (ch[0][c] * (scale - fu) + ch[1][c] * fu) >> `TEX_FRAC_BITS;
                bot = (ch[2][c] * (scale - fu) + ch[3][c] * fu) >> `TEX_FRAC_BITS;
                val = (top * (scale - fv) + bot * fv) >> `TEX_FRAC_BITS;
                res[(3 - c) * 8 +: 8] = val[7:0];
            end
        end
        return res;
    endfunction

    task automatic check_color(
        input rgba_t       got,
        input rgba_t       exp,
        input tex_coord_t  u,
        input tex_coord_t  v,
        input tex_format_e fmt
    );
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: rsp_color got %h expected %h for u %h v %h fmt %s",
                     $time, got, exp, u, v, fmt.name());
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: rsp_valid got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %0d errors", name, n_errors - errs_before);
    endtask

    // one idle slot on both ports
    task automatic idle_cycle();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        wr_en = 1'b0;
    endtask

    task automatic write_texel(input tex_addr_t addr, input texel_raw_t data);
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        shadow[addr] = data;
    endtask

    task automatic send_req(input tex_coord_t u, input tex_coord_t v, input tex_format_e fmt);
        exp_t e;
        @(posedge clk);
        #2;
        wr_en = 1'b0;
        req_valid = 1'b1;
        req_u = u;
        req_v = v;
        req_fmt = fmt;
        // first of four register stages at the next edge, response after the fourth
        e.due = cycle + 4;
        e.u = u;
        e.v = v;
        e.fmt = fmt;
        e.color = ref_sample(u, v, fmt);
        exp_q.push_back(e);
    endtask

    // idle until every response is back
    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        idle_cycle();
    endtask

    // compare at the falling edge, outputs settled
    initial begin : compare
        exp_t e;
        logic exp_valid;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            exp_valid = (exp_q.size() > 0) && (exp_q[0].due == cycle);
            check_valid(rsp_valid, exp_valid);
            if (exp_valid) begin
                e = exp_q.pop_front();
                if (rsp_valid) begin
                    check_color(rsp_color, e.color, e.u, e.v, e.fmt);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("run stopped after %0d cycles, %0d responses still owed", cycle, exp_q.size());
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int errs;
        int x;
        int y;
        tex_coord_t u;
        tex_coord_t v;
        tex_addr_t a;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_u = '0;
        req_v = '0;
        req_fmt = fmt_r5g6b5;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // 1: quiet after reset and through the load
        errs = n_errors;
        repeat (10) idle_cycle();
        for (int i = 0; i < `TEX_NUM_WORDS; i++) begin
            write_texel(tex_addr_t'(i), texel_raw_t'($random(seed)));
        end
        repeat (8) idle_cycle();
        report_test("1 idle and load", errs);

        // 2: zero fractions give the single texel
        errs = n_errors;
        for (int p = 0; p < NUM_POINT; p++) begin
            if (p % 8 < 4) begin
                x = (p % 2) * (`TEX_DIM - 1);
                y = ((p / 2) % 2) * (`TEX_DIM - 1);
            end else begin
                x = rand_below(`TEX_DIM);
                y = rand_below(`TEX_DIM);
            end
            send_req(tex_coord_t'(x << `TEX_FRAC_BITS), tex_coord_t'(y << `TEX_FRAC_BITS),
                     fmt_pick(p / 8));
            drain();
        end
        report_test("2 point samples", errs);

        // 3: random blends, some forced onto the last row or column
        errs = n_errors;
        for (int i = 0; i < NUM_RAND; i++) begin
            u = tex_coord_t'($random(seed));
            v = tex_coord_t'($random(seed));
            if (i % 4 == 0 || i % 4 == 2) begin
                u = u | tex_coord_t'((`TEX_DIM - 1) << `TEX_FRAC_BITS);
            end
            if (i % 4 == 1 || i % 4 == 2) begin
                v = v | tex_coord_t'((`TEX_DIM - 1) << `TEX_FRAC_BITS);
            end
            send_req(u, v, fmt_pick(rand_below(3)));
            repeat (rand_below(3)) idle_cycle();
        end
        drain();
        report_test("3 random blends", errs);

        // 4: one request per cycle
        errs = n_errors;
        for (int i = 0; i < NUM_B2B; i++) begin
            send_req(tex_coord_t'($random(seed)), tex_coord_t'($random(seed)), fmt_pick(i));
        end
        drain();
        report_test("4 back to back", errs);

        // 5: rewrite a texel between two samples of it
        errs = n_errors;
        for (int j = 0; j < NUM_REWR; j++) begin
            x = rand_below(`TEX_DIM);
            y = rand_below(`TEX_DIM);
            u = tex_coord_t'(x << `TEX_FRAC_BITS);
            v = tex_coord_t'(y << `TEX_FRAC_BITS);
            a = tex_addr_t'(y * `TEX_DIM + x);
            send_req(u, v, fmt_pick(j));
            drain();
            // every bit flips so every channel changes
            write_texel(a, ~shadow[a]);
            send_req(u, v, fmt_pick(j));
            drain();
        end
        report_test("5 texel rewrite", errs);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+hw
hw/tex_pkg.sv
hw/tex_stage_if.sv
hw/tex_addr.sv
hw/tex_mem.sv
hw/tex_format.sv
hw/tex_filter.sv
hw/tex_unit.sv
bench/tb_tex_unit.sv

// File: run.sh
#!/bin/sh
# build the texture unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f sim.f --top-module tb_tex_unit -Mdir obj_dir -o tb_tex_unit; then
    echo "verilator build failed"
    exit 1
fi

# keep the simulation output in a variable, no log file
out=$(./obj_dir/tb_tex_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
